// File: tb.f
rtl/sgmii_reg_pkg.sv
rtl/sgmii_axil_wr.sv
rtl/sgmii_axil_rd.sv
rtl/sgmii_ctrl_regs.sv
rtl/sgmii_reg_if.sv
verif/sgmii_reg_checks.sv
verif/sgmii_reg_if_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := sgmii_reg_if_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
FLAGS     := --timing --assert --timescale 1ns/1ps --top-module $(TOP)
PASS_MSG  := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: verif/sgmii_reg_if_tb.sv
// All DUT inputs change 1 ns after a rising edge; tasks start and end at that point
// Values are checked by the assertions in sgmii_reg_checks
module sgmii_reg_if_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES   = 16;
  localparam int CYCLES_PER_TXN = 200;

  logic                   S_AXI_ACLK = 1'b0;
  logic                   S_AXI_ARESETN;
  sgmii_reg_pkg::addr_t   S_AXI_AWADDR, S_AXI_ARADDR;
  sgmii_reg_pkg::data_t   S_AXI_WDATA, S_AXI_RDATA;
  sgmii_reg_pkg::strb_t   S_AXI_WSTRB;
  sgmii_reg_pkg::resp_t   S_AXI_BRESP, S_AXI_RRESP;
  logic                   S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY;
  logic                   S_AXI_BVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_ARREADY;
  logic                   S_AXI_RVALID, S_AXI_RREADY;
  logic                   sgmii_reset, signal_detect, configuration_valid;
  logic                   an_adv_config_val, an_restart_config;
  sgmii_reg_pkg::config_t configuration_vector;
  sgmii_reg_pkg::an_adv_t an_adv_config_vector;
  sgmii_reg_pkg::data_t   cnt_ctrl;
  sgmii_reg_pkg::status_t status_vector;
  logic                   gmii_isolate, mcmm_locked;
  sgmii_reg_pkg::data_t   mdc_cnt, gmii_rxclk_cnt, gmii_txclk_cnt;

  int txn_count    = 0;
  int cycle_count  = 0;
  int err_base     = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  sgmii_reg_if dut_i (.*);

  sgmii_reg_checks checks_i (.*);

  always #2 S_AXI_ACLK = ~S_AXI_ACLK;

  always @(posedge S_AXI_ACLK)
    cycle_count <= cycle_count + 1;

  //////////////////////////////
  // AXI driver tasks
  //////////////////////////////
  task automatic next_cycle();
    @(posedge S_AXI_ACLK);
    #1;
  endtask

  // Address and data together, held until the handshake edge
  task automatic write_addr(input sgmii_reg_pkg::reg_idx_t idx, input sgmii_reg_pkg::data_t data,
                            input sgmii_reg_pkg::strb_t strb);
    S_AXI_AWADDR  = {idx, 2'b00};
    S_AXI_WDATA   = data;
    S_AXI_WSTRB   = strb;
    S_AXI_AWVALID = 1'b1;
    S_AXI_WVALID  = 1'b1;
    txn_count++;
    while (!S_AXI_AWREADY)
      next_cycle();
    next_cycle();
    S_AXI_AWVALID = 1'b0;
    S_AXI_WVALID  = 1'b0;
  endtask

  // Hold BREADY low for stall cycles once BVALID is up
  task automatic take_bresp(input int stall);
    while (!S_AXI_BVALID)
      next_cycle();
    repeat (stall)
      next_cycle();
    S_AXI_BREADY = 1'b1;
    next_cycle();
    S_AXI_BREADY = 1'b0;
  endtask

  task automatic read_addr(input sgmii_reg_pkg::reg_idx_t idx);
    S_AXI_ARADDR  = {idx, 2'b00};
    S_AXI_ARVALID = 1'b1;
    txn_count++;
    while (!S_AXI_ARREADY)
      next_cycle();
    next_cycle();
    S_AXI_ARVALID = 1'b0;
  endtask

  task automatic take_rdata(input int stall);
    while (!S_AXI_RVALID)
      next_cycle();
    repeat (stall)
      next_cycle();
    S_AXI_RREADY = 1'b1;
    next_cycle();
    S_AXI_RREADY = 1'b0;
  endtask

  task automatic write_reg(input sgmii_reg_pkg::reg_idx_t idx, input sgmii_reg_pkg::data_t data,
                           input sgmii_reg_pkg::strb_t strb);
    write_addr(idx, data, strb);
    take_bresp(0);
  endtask

  task automatic read_reg(input sgmii_reg_pkg::reg_idx_t idx);
    read_addr(idx);
    take_rdata(0);
  endtask

  // Writable indices 0, 2, 3, 4
  function automatic sgmii_reg_pkg::reg_idx_t ctrl_index(input logic [1:0] k);
    case (k)
      2'd0:    return sgmii_reg_pkg::REG_CTRL;
      2'd1:    return sgmii_reg_pkg::REG_CONFIG;
      2'd2:    return sgmii_reg_pkg::REG_AN_ADV;
      default: return sgmii_reg_pkg::REG_CNT_CTRL;
    endcase
  endfunction

  // Read-only indices 1, 5, 6, 7
  function automatic sgmii_reg_pkg::reg_idx_t ro_index(input logic [1:0] k);
    return (k == 2'd0) ? sgmii_reg_pkg::REG_STATUS : {1'b1, k};
  endfunction

  // Let the last response settle through the assertions, then report
  task automatic end_test(input string name);
    int errs;
    repeat (2)
      next_cycle();
    errs     = checks_i.err_count - err_base;
    err_base = checks_i.err_count;
    tests_run++;
    if (errs != 0)
      tests_failed++;
    $display("test %0d %s: %0d errors", tests_run, name, errs);
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial
  begin : stimulus
    sgmii_reg_pkg::reg_idx_t idx;
    void'($urandom(32'h04826db6));
    {S_AXI_AWADDR, S_AXI_ARADDR, S_AXI_WDATA, S_AXI_WSTRB} = '0;
    {S_AXI_AWVALID, S_AXI_WVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_RREADY} = '0;
    {status_vector, gmii_isolate, mcmm_locked} = '0;
    {mdc_cnt, gmii_rxclk_cnt, gmii_txclk_cnt} = '0;
    S_AXI_ARESETN = 1'b0;
    repeat (RESET_CYCLES)
      @(posedge S_AXI_ACLK);
    #1;
    S_AXI_ARESETN = 1'b1;
    next_cycle();

    for (int i = 0; i < 4; i++)
      read_reg(ctrl_index(2'(i)));
    end_test("reset values");

    for (int i = 0; i < 4; i++)
    begin
      write_reg(ctrl_index(2'(i)), $urandom, 4'hf);
      read_reg(ctrl_index(2'(i)));
    end
    end_test("full-strobe writes");

    repeat (12)
    begin
      idx = ctrl_index(2'($urandom));
      write_reg(idx, $urandom, 4'($urandom));
      read_reg(idx);
    end
    end_test("partial strobes");

    // Status and counters change only between transactions
    status_vector  = 16'($urandom);
    gmii_isolate   = 1'($urandom);
    mcmm_locked    = 1'($urandom);
    mdc_cnt        = $urandom;
    gmii_rxclk_cnt = $urandom;
    gmii_txclk_cnt = $urandom;
    for (int i = 0; i < 4; i++)
    begin
      read_reg(ro_index(2'(i)));
      write_reg(ro_index(2'(i)), $urandom, 4'hf);
    end
    for (int i = 0; i < 4; i++)
      read_reg(ctrl_index(2'(i)));
    end_test("read-only words");

    // Second transaction waits behind a stalled response
    write_addr(sgmii_reg_pkg::REG_CONFIG, $urandom, 4'hf);
    fork
      take_bresp(6);
      begin
        next_cycle();
        write_addr(sgmii_reg_pkg::REG_CNT_CTRL, $urandom, 4'b0101);
      end
    join
    take_bresp(3);
    read_addr(sgmii_reg_pkg::REG_CONFIG);
    fork
      take_rdata(6);
      begin
        next_cycle();
        read_addr(sgmii_reg_pkg::REG_CNT_CTRL);
      end
    join
    take_rdata(3);
    end_test("back-pressure");

    // Write and read in flight together on the same index
    repeat (4)
    begin
      idx = ctrl_index(2'($urandom));
      fork
        write_reg(idx, $urandom, 4'($urandom));
        read_reg(idx);
      join
      read_reg(idx);
    end
    end_test("both channels");

    $display("%0d tests, %0d with errors, %0d errors in total",
             tests_run, tests_failed, checks_i.err_count);
    if (checks_i.err_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // Budget grows with every issued transaction
  initial
  begin : watchdog
    while (cycle_count < RESET_CYCLES + CYCLES_PER_TXN * (txn_count + 1))
      @(posedge S_AXI_ACLK);
    $display("Timeout: the DUT stopped answering after %0d transactions", txn_count);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: verif/sgmii_reg_checks.sv
// Sees only DUT ports; the control word model follows the observed write handshakes
// err_count is read by the testbench at the end of each test
module sgmii_reg_checks
(
  input logic                   S_AXI_ACLK, S_AXI_ARESETN,
  input sgmii_reg_pkg::addr_t   S_AXI_AWADDR, S_AXI_ARADDR,
  input sgmii_reg_pkg::data_t   S_AXI_WDATA, S_AXI_RDATA,
  input sgmii_reg_pkg::strb_t   S_AXI_WSTRB,
  input sgmii_reg_pkg::resp_t   S_AXI_BRESP, S_AXI_RRESP,
  input logic                   S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY,
  input logic                   S_AXI_BVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_ARREADY,
  input logic                   S_AXI_RVALID, S_AXI_RREADY,
  input logic                   sgmii_reset, signal_detect, configuration_valid,
  input logic                   an_adv_config_val, an_restart_config,
  input sgmii_reg_pkg::config_t configuration_vector,
  input sgmii_reg_pkg::an_adv_t an_adv_config_vector,
  input sgmii_reg_pkg::data_t   cnt_ctrl,
  input sgmii_reg_pkg::status_t status_vector,
  input logic                   gmii_isolate, mcmm_locked,
  input sgmii_reg_pkg::data_t   mdc_cnt, gmii_rxclk_cnt, gmii_txclk_cnt
);
  timeunit 1ns;
  timeprecision 1ps;

  int err_count = 0;

  // Model words, only the control indices are ever written
  sgmii_reg_pkg::data_t    ctl_m [8];
  sgmii_reg_pkg::data_t    exp_rdata;
  sgmii_reg_pkg::reg_idx_t widx;
  logic                    wr_fire;
  logic                    wr_start;
  logic                    rd_start;

  assign widx     = S_AXI_AWADDR[sgmii_reg_pkg::ADDR_WIDTH-1:sgmii_reg_pkg::ADDR_LSB];
  assign wr_fire  = S_AXI_AWVALID && S_AXI_AWREADY && S_AXI_WVALID && S_AXI_WREADY;
  // First edge of a write or read that the slave must take up
  assign wr_start = S_AXI_AWVALID && S_AXI_WVALID && !S_AXI_AWREADY && !S_AXI_BVALID;
  assign rd_start = S_AXI_ARVALID && !S_AXI_ARREADY && !S_AXI_RVALID;

  task automatic count_error(input string msg);
    err_count++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  // One byte of ones per set strobe
  function automatic sgmii_reg_pkg::data_t lane_mask(input sgmii_reg_pkg::strb_t strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  function automatic sgmii_reg_pkg::data_t expected_word(input sgmii_reg_pkg::reg_idx_t idx);
    case (idx)
      sgmii_reg_pkg::REG_STATUS:    return {14'd0, mcmm_locked, gmii_isolate, status_vector};
      sgmii_reg_pkg::REG_MDC_CNT:   return mdc_cnt;
      sgmii_reg_pkg::REG_TXCLK_CNT: return gmii_txclk_cnt;
      sgmii_reg_pkg::REG_RXCLK_CNT: return gmii_rxclk_cnt;
      default:                      return ctl_m[idx];
    endcase
  endfunction

  //////////////////////////////
  // Register map model
  //////////////////////////////
  always @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      ctl_m <= '{default: '0};
    else
    begin
      if (wr_fire && (widx inside {sgmii_reg_pkg::REG_CTRL, sgmii_reg_pkg::REG_CONFIG,
                                   sgmii_reg_pkg::REG_AN_ADV, sgmii_reg_pkg::REG_CNT_CTRL}))
        ctl_m[widx] <= (ctl_m[widx] & ~lane_mask(S_AXI_WSTRB))
                       | (S_AXI_WDATA & lane_mask(S_AXI_WSTRB));
      // Word seen by the read at its address handshake, before any write of that edge
      if (S_AXI_ARREADY && S_AXI_ARVALID)
        exp_rdata <= expected_word(S_AXI_ARADDR[sgmii_reg_pkg::ADDR_WIDTH-1:sgmii_reg_pkg::ADDR_LSB]);
    end
  end

  //////////////////////////////
  // Handshake and timing
  //////////////////////////////
  assert property (@(posedge S_AXI_ACLK) $rose(S_AXI_ARESETN) |->
    !(S_AXI_AWREADY || S_AXI_WREADY || S_AXI_BVALID || S_AXI_ARREADY || S_AXI_RVALID)
    && S_AXI_BRESP == sgmii_reg_pkg::RESP_OKAY && S_AXI_RRESP == sgmii_reg_pkg::RESP_OKAY
    && S_AXI_RDATA == '0)
    else count_error("ready, valid or response not cleared by reset");

  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    wr_start |=> S_AXI_AWREADY && S_AXI_WREADY)
    else count_error("AWREADY/WREADY missing one edge after both write valids");
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_AWREADY && S_AXI_AWVALID |=> S_AXI_BVALID && S_AXI_BRESP == sgmii_reg_pkg::RESP_OKAY)
    else count_error("BVALID with OKAY missing after the write handshake");
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    $rose(S_AXI_BVALID) |-> $past(S_AXI_AWREADY && S_AXI_AWVALID))
    else count_error("BVALID rose without a write handshake");
  // No new write while a response waits, and the response holds still
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID |-> !S_AXI_AWREADY)
    else count_error("write accepted while BVALID pending");
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID && $stable(S_AXI_BRESP))
    else count_error("BVALID or BRESP changed under back-pressure");

  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    rd_start |=> S_AXI_ARREADY)
    else count_error("ARREADY missing one edge after ARVALID");
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_ARREADY && S_AXI_ARVALID |=> S_AXI_RVALID && S_AXI_RRESP == sgmii_reg_pkg::RESP_OKAY)
    else count_error("RVALID with OKAY missing after the read handshake");
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    $rose(S_AXI_RVALID) |-> $past(S_AXI_ARREADY && S_AXI_ARVALID))
    else count_error("RVALID rose without a read handshake");
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_RVALID |-> !S_AXI_ARREADY)
    else count_error("read accepted while RVALID pending");
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA)
    && $stable(S_AXI_RRESP))
    else count_error("RVALID, RDATA or RRESP changed under back-pressure");

  //////////////////////////////
  // Data against the model
  //////////////////////////////
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_RVALID && S_AXI_RREADY |-> S_AXI_RDATA == exp_rdata)
    else count_error($sformatf("RDATA %h, expected %h", S_AXI_RDATA, exp_rdata));

  // PHY fields follow the bit layout of the stored words
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    sgmii_reset == ctl_m[sgmii_reg_pkg::REG_CTRL][0]
    && signal_detect == ctl_m[sgmii_reg_pkg::REG_CTRL][1]
    && configuration_vector == ctl_m[sgmii_reg_pkg::REG_CONFIG][4:0]
    && configuration_valid == ctl_m[sgmii_reg_pkg::REG_CONFIG][5]
    && an_adv_config_vector == ctl_m[sgmii_reg_pkg::REG_AN_ADV][15:0]
    && an_adv_config_val == ctl_m[sgmii_reg_pkg::REG_AN_ADV][16]
    && an_restart_config == ctl_m[sgmii_reg_pkg::REG_AN_ADV][17]
    && cnt_ctrl == ctl_m[sgmii_reg_pkg::REG_CNT_CTRL])
    else count_error("PHY control output differs from the register model");

endmodule

// File: rtl/sgmii_reg_if.sv
// AXI4-Lite slave for the SGMII PHY control bank, always answers OKAY
// Write and read channels run independently, one transfer each in flight
module sgmii_reg_if
(
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  // Write address and data
  input  sgmii_reg_pkg::addr_t    S_AXI_AWADDR,
  input  logic                    S_AXI_AWVALID,
  output logic                    S_AXI_AWREADY,
  input  sgmii_reg_pkg::data_t    S_AXI_WDATA,
  input  sgmii_reg_pkg::strb_t    S_AXI_WSTRB,
  input  logic                    S_AXI_WVALID,
  output logic                    S_AXI_WREADY,
  // Write response
  output sgmii_reg_pkg::resp_t    S_AXI_BRESP,
  output logic                    S_AXI_BVALID,
  input  logic                    S_AXI_BREADY,
  // Read address and data
  input  sgmii_reg_pkg::addr_t    S_AXI_ARADDR,
  input  logic                    S_AXI_ARVALID,
  output logic                    S_AXI_ARREADY,
  output sgmii_reg_pkg::data_t    S_AXI_RDATA,
  output sgmii_reg_pkg::resp_t    S_AXI_RRESP,
  output logic                    S_AXI_RVALID,
  input  logic                    S_AXI_RREADY,
  // PHY controls
  output logic                    sgmii_reset,
  output logic                    signal_detect,
  output sgmii_reg_pkg::config_t  configuration_vector,
  output logic                    configuration_valid,
  output sgmii_reg_pkg::an_adv_t  an_adv_config_vector,
  output logic                    an_adv_config_val,
  output logic                    an_restart_config,
  output sgmii_reg_pkg::data_t    cnt_ctrl,
  // PHY status and clock counters
  input  sgmii_reg_pkg::status_t  status_vector,
  input  logic                    gmii_isolate,
  input  logic                    mcmm_locked,
  input  sgmii_reg_pkg::data_t    mdc_cnt,
  input  sgmii_reg_pkg::data_t    gmii_rxclk_cnt,
  input  sgmii_reg_pkg::data_t    gmii_txclk_cnt
);

  //////////////////////////////
  // Bank access
  //////////////////////////////
  logic                    wr_en;
  sgmii_reg_pkg::reg_idx_t wr_idx;
  sgmii_reg_pkg::data_t    wr_data;
  sgmii_reg_pkg::strb_t    wr_strb;
  sgmii_reg_pkg::reg_idx_t rd_idx;
  sgmii_reg_pkg::data_t    rd_data;

  sgmii_axil_wr wr_i (.*);

  sgmii_axil_rd rd_i (.*);

  // Register bank with PHY field decode
  sgmii_ctrl_regs regs_i (.*);

endmodule

// File: rtl/sgmii_ctrl_regs.sv
// Writes to the read-only indices 1, 5, 6 and 7 are dropped
// Status and counter inputs are read as-is, no synchronization here
module sgmii_ctrl_regs
(
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  input  logic                     wr_en,
  input  sgmii_reg_pkg::reg_idx_t  wr_idx,
  input  sgmii_reg_pkg::data_t     wr_data,
  input  sgmii_reg_pkg::strb_t     wr_strb,
  input  sgmii_reg_pkg::reg_idx_t  rd_idx,
  output sgmii_reg_pkg::data_t     rd_data,
  input  sgmii_reg_pkg::status_t   status_vector,
  input  logic                     gmii_isolate,
  input  logic                     mcmm_locked,
  input  sgmii_reg_pkg::data_t     mdc_cnt,
  input  sgmii_reg_pkg::data_t     gmii_rxclk_cnt,
  input  sgmii_reg_pkg::data_t     gmii_txclk_cnt,
  output logic                     sgmii_reset,
  output logic                     signal_detect,
  output sgmii_reg_pkg::config_t   configuration_vector,
  output logic                     configuration_valid,
  output sgmii_reg_pkg::an_adv_t   an_adv_config_vector,
  output logic                     an_adv_config_val,
  output logic                     an_restart_config,
  output sgmii_reg_pkg::data_t     cnt_ctrl
);

  // Stored control words
  sgmii_reg_pkg::data_t ctrl_q;
  sgmii_reg_pkg::data_t config_q;
  sgmii_reg_pkg::data_t an_adv_q;
  sgmii_reg_pkg::data_t cnt_ctrl_q;

  // Replace only the byte lanes whose strobe is set
  function automatic sgmii_reg_pkg::data_t merge_bytes(input sgmii_reg_pkg::data_t old_word,
                                                       input sgmii_reg_pkg::data_t new_word,
                                                       input sgmii_reg_pkg::strb_t strb);
    sgmii_reg_pkg::data_t merged;
    merged = old_word;
    for (int i = 0; i < sgmii_reg_pkg::DATA_WIDTH / 8; i++)
    begin
      if (strb[i])
        merged[i*8 +: 8] = new_word[i*8 +: 8];
    end
    return merged;
  endfunction

  //////////////////////////////
  // Write side
  //////////////////////////////
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      ctrl_q     <= '0;
      config_q   <= '0;
      an_adv_q   <= '0;
      cnt_ctrl_q <= '0;
    end
    else if (wr_en)
    begin
      case (wr_idx)
        sgmii_reg_pkg::REG_CTRL:     ctrl_q     <= merge_bytes(ctrl_q, wr_data, wr_strb);
        sgmii_reg_pkg::REG_CONFIG:   config_q   <= merge_bytes(config_q, wr_data, wr_strb);
        sgmii_reg_pkg::REG_AN_ADV:   an_adv_q   <= merge_bytes(an_adv_q, wr_data, wr_strb);
        sgmii_reg_pkg::REG_CNT_CTRL: cnt_ctrl_q <= merge_bytes(cnt_ctrl_q, wr_data, wr_strb);
        // Read-only words have no storage
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Read mux
  //////////////////////////////
  always_comb
  begin
    case (rd_idx)
      sgmii_reg_pkg::REG_CTRL:      rd_data = ctrl_q;
      // Lock at bit 17, isolate at bit 16, zeros above
      sgmii_reg_pkg::REG_STATUS:    rd_data = {14'd0, mcmm_locked, gmii_isolate, status_vector};
      sgmii_reg_pkg::REG_CONFIG:    rd_data = config_q;
      sgmii_reg_pkg::REG_AN_ADV:    rd_data = an_adv_q;
      sgmii_reg_pkg::REG_CNT_CTRL:  rd_data = cnt_ctrl_q;
      sgmii_reg_pkg::REG_MDC_CNT:   rd_data = mdc_cnt;
      sgmii_reg_pkg::REG_TXCLK_CNT: rd_data = gmii_txclk_cnt;
      sgmii_reg_pkg::REG_RXCLK_CNT: rd_data = gmii_rxclk_cnt;
      default:                      rd_data = '0;
    endcase
  end

  // PHY control fields
  assign sgmii_reset          = ctrl_q[0];
  assign signal_detect        = ctrl_q[1];
  assign configuration_vector = config_q[4:0];
  assign configuration_valid  = config_q[5];
  assign an_adv_config_vector = an_adv_q[15:0];
  assign an_adv_config_val    = an_adv_q[16];
  assign an_restart_config    = an_adv_q[17];
  assign cnt_ctrl             = cnt_ctrl_q;

endmodule

// File: rtl/sgmii_axil_rd.sv
// One read in flight; a new read waits until RVALID has been taken
// RDATA is sampled from the register bank at the address handshake
module sgmii_axil_rd
(
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  input  sgmii_reg_pkg::addr_t     S_AXI_ARADDR,
  input  logic                     S_AXI_ARVALID,
  output logic                     S_AXI_ARREADY,
  output sgmii_reg_pkg::data_t     S_AXI_RDATA,
  output sgmii_reg_pkg::resp_t     S_AXI_RRESP,
  output logic                     S_AXI_RVALID,
  input  logic                     S_AXI_RREADY,
  output sgmii_reg_pkg::reg_idx_t  rd_idx,
  input  sgmii_reg_pkg::data_t     rd_data
);

  logic accept;
  logic rd_fire;

  // Fresh address, no handshake underway and no data waiting
  assign accept  = S_AXI_ARVALID && !S_AXI_ARREADY && !S_AXI_RVALID;
  assign rd_fire = S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID;

  //////////////////////////////
  // Address channel
  //////////////////////////////
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      S_AXI_ARREADY <= 1'b0;
    else
      S_AXI_ARREADY <= accept;
  end

  // Index stays put until the next accepted read
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (accept)
      rd_idx <= S_AXI_ARADDR[sgmii_reg_pkg::ADDR_WIDTH-1:sgmii_reg_pkg::ADDR_LSB];
  end

  //////////////////////////////
  // Data channel
  //////////////////////////////
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      S_AXI_RVALID <= 1'b0;
      S_AXI_RRESP  <= sgmii_reg_pkg::RESP_OKAY;
      S_AXI_RDATA  <= '0;
    end
    else if (rd_fire)
    begin
      S_AXI_RVALID <= 1'b1;
      S_AXI_RRESP  <= sgmii_reg_pkg::RESP_OKAY;
      // Mux output registered here, held through back-pressure
      S_AXI_RDATA  <= rd_data;
    end
    else if (S_AXI_RREADY)
      S_AXI_RVALID <= 1'b0;
  end

  // Read data and its valid stay frozen while the master stalls
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA));

endmodule

// File: rtl/sgmii_axil_wr.sv
// Address and data must arrive together; one write in flight at a time
// A new write waits until the pending BVALID has been taken
module sgmii_axil_wr
(
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  input  sgmii_reg_pkg::addr_t     S_AXI_AWADDR,
  input  logic                     S_AXI_AWVALID,
  output logic                     S_AXI_AWREADY,
  input  sgmii_reg_pkg::data_t     S_AXI_WDATA,
  input  sgmii_reg_pkg::strb_t     S_AXI_WSTRB,
  input  logic                     S_AXI_WVALID,
  output logic                     S_AXI_WREADY,
  output sgmii_reg_pkg::resp_t     S_AXI_BRESP,
  output logic                     S_AXI_BVALID,
  input  logic                     S_AXI_BREADY,
  output logic                     wr_en,
  output sgmii_reg_pkg::reg_idx_t  wr_idx,
  output sgmii_reg_pkg::data_t     wr_data,
  output sgmii_reg_pkg::strb_t     wr_strb
);

  logic accept;

  // Both valids seen, not already in the handshake cycle, no response pending
  assign accept = S_AXI_AWVALID && S_AXI_WVALID && !S_AXI_AWREADY && !S_AXI_BVALID;

  // Handshake edge on both channels at once
  assign wr_en   = S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WREADY && S_AXI_WVALID;
  assign wr_data = S_AXI_WDATA;
  assign wr_strb = S_AXI_WSTRB;

  //////////////////////////////
  // Ready pulse and address
  //////////////////////////////
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      S_AXI_AWREADY <= 1'b0;
      S_AXI_WREADY  <= 1'b0;
    end
    else
    begin
      // One cycle wide, drops right after the handshake
      S_AXI_AWREADY <= accept;
      S_AXI_WREADY  <= accept;
    end
  end

  // Word index latched together with the ready pulse
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (accept)
      wr_idx <= S_AXI_AWADDR[sgmii_reg_pkg::ADDR_WIDTH-1:sgmii_reg_pkg::ADDR_LSB];
  end

  //////////////////////////////
  // Write response
  //////////////////////////////
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      S_AXI_BVALID <= 1'b0;
      S_AXI_BRESP  <= sgmii_reg_pkg::RESP_OKAY;
    end
    else if (wr_en)
    begin
      S_AXI_BVALID <= 1'b1;
      S_AXI_BRESP  <= sgmii_reg_pkg::RESP_OKAY;
    end
    else if (S_AXI_BREADY)
      S_AXI_BVALID <= 1'b0;
  end

  // Address and data channels always handshake together
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_AWREADY == S_AXI_WREADY);

  // Ready is a single-cycle pulse
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_AWREADY |=> !S_AXI_AWREADY);

  // Response held until the master takes it
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID);

endmodule

// File: rtl/sgmii_reg_pkg.sv
// Register map is fixed at 32-bit data and 5-bit byte addresses
// Only eight word indices are decoded; address bits 1:0 are ignored
package sgmii_reg_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 5;
  // Byte offset bits below the word index
  localparam int ADDR_LSB   = 2;

  typedef logic [DATA_WIDTH-1:0]          data_t;
  typedef logic [ADDR_WIDTH-1:0]          addr_t;
  typedef logic [DATA_WIDTH/8-1:0]        strb_t;
  typedef logic [1:0]                     resp_t;
  typedef logic [ADDR_WIDTH-ADDR_LSB-1:0] reg_idx_t;

  // Only response this slave ever returns
  localparam resp_t RESP_OKAY = 2'b00;

  //////////////////////////////
  // Register indices
  //////////////////////////////
  localparam reg_idx_t REG_CTRL      = 3'd0;
  localparam reg_idx_t REG_STATUS    = 3'd1;
  localparam reg_idx_t REG_CONFIG    = 3'd2;
  localparam reg_idx_t REG_AN_ADV    = 3'd3;
  localparam reg_idx_t REG_CNT_CTRL  = 3'd4;
  localparam reg_idx_t REG_MDC_CNT   = 3'd5;
  localparam reg_idx_t REG_TXCLK_CNT = 3'd6;
  localparam reg_idx_t REG_RXCLK_CNT = 3'd7;

  // PHY side vectors
  typedef logic [15:0] status_t;
  typedef logic [4:0]  config_t;
  typedef logic [15:0] an_adv_t;

endpackage
